//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int nregs = 32;
    localparam int reg_aw = $clog2(nregs);
    localparam logic [xlen-1:0] reset_pc = '0;

    // low bit of each instruction field
    localparam int f_opc_lo = 2;
    localparam int f_rd_lo = 7;
    localparam int f_funct3_lo = 12;
    localparam int f_rs1_lo = 15;
    localparam int f_rs2_lo = 20;
    // funct7 bit 5 selects SUB and SRA
    localparam int f_alt_bit = 30;

    typedef logic [31:0] inst_t;

    // --------------------
    // encodings
    // --------------------

    // opcode bits 6:2, the low two bits are always 2'b11 in RV32I
    typedef enum logic [4:0] {
        opc_load   = 5'b00000,
        opc_op_imm = 5'b00100,
        opc_auipc  = 5'b00101,
        opc_store  = 5'b01000,
        opc_op     = 5'b01100,
        opc_lui    = 5'b01101,
        opc_branch = 5'b11000,
        opc_jalr   = 5'b11001,
        opc_jal    = 5'b11011
    } opcode_e;

    typedef enum logic [2:0] {
        fn_beq  = 3'b000,
        fn_bne  = 3'b001,
        fn_blt  = 3'b100,
        fn_bge  = 3'b101,
        fn_bltu = 3'b110,
        fn_bgeu = 3'b111
    } br_fn_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_pc_plus4 = 2'b00,
        wb_mem      = 2'b01,
        wb_alu      = 2'b10
    } wb_sel_e;

    // --------------------
    // control bundles
    // --------------------

    typedef struct packed {
        alu_op_e alu_op;
        logic    a_sel;
        logic    b_sel;
        logic    brun;
        logic    dmem_we;
    } ex_ctrl_t;

    typedef struct packed {
        logic    reg_we;
        wb_sel_e wb_sel;
    } wb_ctrl_t;

    typedef struct packed {
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   data;
    } trace_t;

endpackage

`default_nettype wire

//--- control/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire rv_pkg::inst_t execute_inst,
    input  wire rv_pkg::inst_t writeback_inst,
    input  wire logic          breq,
    input  wire logic          brlt,
    output rv_pkg::ex_ctrl_t   ex_ctrl,
    output rv_pkg::wb_ctrl_t   wb_ctrl,
    output logic               pc_sel
);

    rv_pkg::opcode_e ex_opc;
    rv_pkg::opcode_e wb_opc;
    rv_pkg::br_fn_e  br_fn;
    rv_pkg::alu_op_e ex_alu_op;
    rv_pkg::wb_sel_e wb_src;
    logic [2:0]      ex_funct3;
    logic            ex_alt;
    logic            br_cond;
    logic            taken;
    logic            wb_we;
    logic            execute_valid;
    logic            writeback_valid;

    assign ex_opc = rv_pkg::opcode_e'(execute_inst[rv_pkg::f_opc_lo +: $bits(rv_pkg::opcode_e)]);
    assign wb_opc = rv_pkg::opcode_e'(writeback_inst[rv_pkg::f_opc_lo +: $bits(rv_pkg::opcode_e)]);
    assign ex_funct3 = execute_inst[rv_pkg::f_funct3_lo +: 3];
    assign br_fn = rv_pkg::br_fn_e'(ex_funct3);
    assign ex_alt = execute_inst[rv_pkg::f_alt_bit];

    // --------------------
    // execute decode
    // --------------------

    // OP-IMM never subtracts, bit 30 there is part of the immediate
    always_comb begin
        ex_alu_op = rv_pkg::alu_add;
        if (ex_opc == rv_pkg::opc_lui) begin
            ex_alu_op = rv_pkg::alu_pass_b;
        end else if (ex_opc == rv_pkg::opc_op || ex_opc == rv_pkg::opc_op_imm) begin
            case (ex_funct3)
                3'b000: begin
                    if (ex_opc == rv_pkg::opc_op && ex_alt) begin
                        ex_alu_op = rv_pkg::alu_sub;
                    end
                end
                3'b001: ex_alu_op = rv_pkg::alu_sll;
                3'b010: ex_alu_op = rv_pkg::alu_slt;
                3'b011: ex_alu_op = rv_pkg::alu_sltu;
                3'b100: ex_alu_op = rv_pkg::alu_xor;
                3'b101: begin
                    if (ex_alt) begin
                        ex_alu_op = rv_pkg::alu_sra;
                    end else begin
                        ex_alu_op = rv_pkg::alu_srl;
                    end
                end
                3'b110: ex_alu_op = rv_pkg::alu_or;
                default: ex_alu_op = rv_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        case (br_fn)
            rv_pkg::fn_beq:  br_cond = breq;
            rv_pkg::fn_bne:  br_cond = !breq;
            rv_pkg::fn_blt,
            rv_pkg::fn_bltu: br_cond = brlt;
            rv_pkg::fn_bge,
            rv_pkg::fn_bgeu: br_cond = !brlt;
            default:         br_cond = 1'b0;
        endcase
    end

    assign taken = (ex_opc == rv_pkg::opc_jal) || (ex_opc == rv_pkg::opc_jalr)
                || (ex_opc == rv_pkg::opc_branch && br_cond);
    assign pc_sel = execute_valid && taken;

    always_comb begin
        ex_ctrl.alu_op = ex_alu_op;
        ex_ctrl.a_sel = ex_opc inside {rv_pkg::opc_auipc, rv_pkg::opc_jal, rv_pkg::opc_branch};
        ex_ctrl.b_sel = (ex_opc != rv_pkg::opc_op);
        ex_ctrl.brun = (ex_opc == rv_pkg::opc_branch)
                    && (br_fn == rv_pkg::fn_bltu || br_fn == rv_pkg::fn_bgeu);
        ex_ctrl.dmem_we = execute_valid && (ex_opc == rv_pkg::opc_store);
    end

    // --------------------
    // writeback decode
    // --------------------

    always_comb begin
        case (wb_opc)
            rv_pkg::opc_jal,
            rv_pkg::opc_jalr: wb_src = rv_pkg::wb_pc_plus4;
            rv_pkg::opc_load: wb_src = rv_pkg::wb_mem;
            default:          wb_src = rv_pkg::wb_alu;
        endcase
    end

    assign wb_we = writeback_valid && (wb_opc inside {rv_pkg::opc_lui, rv_pkg::opc_auipc,
        rv_pkg::opc_jal, rv_pkg::opc_jalr, rv_pkg::opc_load, rv_pkg::opc_op_imm,
        rv_pkg::opc_op});

    assign wb_ctrl = '{reg_we: wb_we, wb_sel: wb_src};

    // fetch is always valid once out of reset, only a taken branch kills it
    always_ff @(posedge clk) begin
        if (rst) begin
            execute_valid <= 1'b0;
            writeback_valid <= 1'b0;
        end else begin
            execute_valid <= !pc_sel;
            writeback_valid <= execute_valid;
        end
    end

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire rv_pkg::ex_ctrl_t         ex_ctrl,
    input  wire rv_pkg::wb_ctrl_t         wb_ctrl,
    input  wire logic                     pc_sel,
    output rv_pkg::inst_t                 execute_inst,
    output rv_pkg::inst_t                 writeback_inst,
    output logic                          breq,
    output logic                          brlt,
    output logic [rv_pkg::xlen-1:0]       imem_addr,
    input  wire rv_pkg::inst_t            imem_rdata,
    output logic [rv_pkg::xlen-1:0]       dmem_addr,
    output logic [rv_pkg::xlen-1:0]       dmem_wdata,
    input  wire logic [rv_pkg::xlen-1:0]  dmem_rdata,
    output logic                          trace_valid,
    output rv_pkg::trace_t                trace
);

    logic [rv_pkg::xlen-1:0]   pc;
    logic [rv_pkg::xlen-1:0]   target;
    logic [rv_pkg::xlen-1:0]   rdata1;
    logic [rv_pkg::xlen-1:0]   rdata2;
    logic [rv_pkg::xlen-1:0]   ex_pc;
    logic [rv_pkg::xlen-1:0]   ex_rs1;
    logic [rv_pkg::xlen-1:0]   ex_rs2;
    logic [rv_pkg::xlen-1:0]   rs1_val;
    logic [rv_pkg::xlen-1:0]   rs2_val;
    logic [rv_pkg::xlen-1:0]   imm;
    logic [rv_pkg::xlen-1:0]   alu_a;
    logic [rv_pkg::xlen-1:0]   alu_b;
    logic [rv_pkg::xlen-1:0]   alu_result;
    logic [rv_pkg::xlen-1:0]   wb_pc4;
    logic [rv_pkg::xlen-1:0]   wb_alu;
    logic [rv_pkg::xlen-1:0]   wb_load;
    logic [rv_pkg::xlen-1:0]   wb_data;
    logic [rv_pkg::reg_aw-1:0] ex_rs1_addr;
    logic [rv_pkg::reg_aw-1:0] ex_rs2_addr;
    logic [rv_pkg::reg_aw-1:0] wb_rd;
    logic                      fwd_en;
    rv_pkg::opcode_e           ex_opc;

    // --------------------
    // fetch and decode
    // --------------------

    // JALR needs bit 0 cleared, branch and JAL targets are already even
    assign target = {alu_result[rv_pkg::xlen-1:1], 1'b0};
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= rv_pkg::reset_pc;
        end else if (pc_sel) begin
            pc <= target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    reg_file u_reg_file (
        .clk    (clk),
        .we     (wb_ctrl.reg_we),
        .waddr  (wb_rd),
        .raddr1 (imem_rdata[rv_pkg::f_rs1_lo +: rv_pkg::reg_aw]),
        .raddr2 (imem_rdata[rv_pkg::f_rs2_lo +: rv_pkg::reg_aw]),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_ff @(posedge clk) begin
        execute_inst <= imem_rdata;
        ex_pc <= pc;
        ex_rs1 <= rdata1;
        ex_rs2 <= rdata2;
    end

    // --------------------
    // execute
    // --------------------

    assign ex_opc = rv_pkg::opcode_e'(execute_inst[rv_pkg::f_opc_lo +: $bits(rv_pkg::opcode_e)]);
    assign ex_rs1_addr = execute_inst[rv_pkg::f_rs1_lo +: rv_pkg::reg_aw];
    assign ex_rs2_addr = execute_inst[rv_pkg::f_rs2_lo +: rv_pkg::reg_aw];

    // the instruction one ahead is in writeback and has not reached the file yet
    assign rs1_val = (fwd_en && wb_rd == ex_rs1_addr) ? wb_data : ex_rs1;
    assign rs2_val = (fwd_en && wb_rd == ex_rs2_addr) ? wb_data : ex_rs2;

    always_comb begin
        case (ex_opc)
            rv_pkg::opc_store:
                imm = {{20{execute_inst[31]}}, execute_inst[31:25], execute_inst[11:7]};
            rv_pkg::opc_branch:
                imm = {{20{execute_inst[31]}}, execute_inst[7], execute_inst[30:25],
                       execute_inst[11:8], 1'b0};
            rv_pkg::opc_lui,
            rv_pkg::opc_auipc:
                imm = {execute_inst[31:12], 12'b0};
            rv_pkg::opc_jal:
                imm = {{12{execute_inst[31]}}, execute_inst[19:12], execute_inst[20],
                       execute_inst[30:21], 1'b0};
            default:
                imm = {{20{execute_inst[31]}}, execute_inst[31:20]};
        endcase
    end

    assign breq = (rs1_val == rs2_val);
    assign brlt = ex_ctrl.brun ? (rs1_val < rs2_val) : ($signed(rs1_val) < $signed(rs2_val));

    assign alu_a = ex_ctrl.a_sel ? ex_pc : rs1_val;
    assign alu_b = ex_ctrl.b_sel ? imm : rs2_val;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ex_ctrl.alu_op),
        .result (alu_result)
    );

    assign dmem_addr = alu_result;
    assign dmem_wdata = rs2_val;

    always_ff @(posedge clk) begin
        writeback_inst <= execute_inst;
        wb_pc4 <= ex_pc + 32'd4;
        wb_alu <= alu_result;
        wb_load <= dmem_rdata;
    end

    // --------------------
    // writeback
    // --------------------

    always_comb begin
        case (wb_ctrl.wb_sel)
            rv_pkg::wb_pc_plus4: wb_data = wb_pc4;
            rv_pkg::wb_mem:      wb_data = wb_load;
            default:             wb_data = wb_alu;
        endcase
    end

    assign wb_rd = writeback_inst[rv_pkg::f_rd_lo +: rv_pkg::reg_aw];
    assign fwd_en = wb_ctrl.reg_we && (wb_rd != '0);

    assign trace_valid = fwd_en;
    assign trace = '{rd: wb_rd, data: wb_data};

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic [rv_pkg::xlen-1:0] a,
    input  wire logic [rv_pkg::xlen-1:0] b,
    input  wire rv_pkg::alu_op_e         op,
    output logic [rv_pkg::xlen-1:0]      result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::alu_add:
                result = a + b;
            rv_pkg::alu_sub:
                result = a - b;
            rv_pkg::alu_sll:
                result = a << shamt;
            rv_pkg::alu_slt:
                result = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu:
                result = {{(rv_pkg::xlen-1){1'b0}}, a < b};
            rv_pkg::alu_xor:
                result = a ^ b;
            rv_pkg::alu_srl:
                result = a >> shamt;
            rv_pkg::alu_sra:
                result = $unsigned($signed(a) >>> shamt);
            rv_pkg::alu_or:
                result = a | b;
            rv_pkg::alu_and:
                result = a & b;
            // LUI already has the upper immediate in b
            rv_pkg::alu_pass_b:
                result = b;
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    output logic [rv_pkg::xlen-1:0]       imem_addr,
    input  wire rv_pkg::inst_t            imem_rdata,
    output logic [rv_pkg::xlen-1:0]       dmem_addr,
    output logic [rv_pkg::xlen-1:0]       dmem_wdata,
    output logic                          dmem_we,
    input  wire logic [rv_pkg::xlen-1:0]  dmem_rdata,
    output logic                          trace_valid,
    output rv_pkg::trace_t                trace
);

    rv_pkg::inst_t    execute_inst;
    rv_pkg::inst_t    writeback_inst;
    rv_pkg::ex_ctrl_t ex_ctrl;
    rv_pkg::wb_ctrl_t wb_ctrl;
    logic             pc_sel;
    logic             breq;
    logic             brlt;

    control u_control (
        .clk            (clk),
        .rst            (rst),
        .execute_inst   (execute_inst),
        .writeback_inst (writeback_inst),
        .breq           (breq),
        .brlt           (brlt),
        .ex_ctrl        (ex_ctrl),
        .wb_ctrl        (wb_ctrl),
        .pc_sel         (pc_sel)
    );

    datapath u_datapath (
        .clk            (clk),
        .rst            (rst),
        .ex_ctrl        (ex_ctrl),
        .wb_ctrl        (wb_ctrl),
        .pc_sel         (pc_sel),
        .execute_inst   (execute_inst),
        .writeback_inst (writeback_inst),
        .breq           (breq),
        .brlt           (brlt),
        .imem_addr      (imem_addr),
        .imem_rdata     (imem_rdata),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_rdata     (dmem_rdata),
        .trace_valid    (trace_valid),
        .trace          (trace)
    );

    // store enable is already qualified by the execute valid bit in control
    assign dmem_we = ex_ctrl.dmem_we;

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                       clk,
    input  wire logic                       we,
    input  wire logic [rv_pkg::reg_aw-1:0]  waddr,
    input  wire logic [rv_pkg::reg_aw-1:0]  raddr1,
    input  wire logic [rv_pkg::reg_aw-1:0]  raddr2,
    input  wire logic [rv_pkg::xlen-1:0]    wdata,
    output logic [rv_pkg::xlen-1:0]         rdata1,
    output logic [rv_pkg::xlen-1:0]         rdata2
);

    logic [rv_pkg::xlen-1:0] regs [rv_pkg::nregs];

    // x0 reads zero, a same-cycle write to the read address is passed through
    function automatic logic [rv_pkg::xlen-1:0] read_port(
        input logic [rv_pkg::reg_aw-1:0] raddr
    );
        if (raddr == '0) begin
            return '0;
        end else if (we && waddr == raddr) begin
            return wdata;
        end
        return regs[raddr];
    endfunction

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f tb.f > build.log 2>&1 \
    && ./obj_dir/Vcpu_tb > sim.log 2>&1
grep -q '^Simulation PASSED$' sim.log \
    && echo "run passed" \
    || { cat build.log sim.log 2>/dev/null; echo "run failed"; exit 1; }

//--- tb.f
common/rv_pkg.sv
design/alu.sv
design/reg_file.sv
control/control.sv
datapath/datapath.sv
design/cpu_top.sv
verification/cpu_sva.sv
verification/cpu_tb.sv

//--- verification/cpu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic pc_sel,
    input wire logic dmem_we,
    input wire logic reg_we
);

    // nothing redirects, stores or writes before the first instruction reaches writeback
    assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> (!pc_sel && !dmem_we && !reg_we) ##1 !reg_we)
        else $error("pc_sel, dmem_we or reg_we before the first instruction reached writeback");

    // the instruction fetched alongside a taken branch is killed in execute and writeback
    assert property (@(posedge clk) disable iff (rst)
        pc_sel |=> (!pc_sel && !dmem_we) ##1 !reg_we)
        else $error("the instruction after a taken branch was not killed");

    assert property (@(posedge clk) disable iff (rst) !$isunknown({pc_sel, dmem_we}))
        else $error("pc_sel or dmem_we is unknown");

endmodule

bind control cpu_sva u_sva (
    .clk     (clk),
    .rst     (rst),
    .pc_sel  (pc_sel),
    .dmem_we (ex_ctrl.dmem_we),
    .reg_we  (wb_ctrl.reg_we)
);

`default_nettype wire

//--- verification/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam logic [31:0] self_jump = 32'h0000006f;

    logic                 clk;
    logic                 rst;
    logic [31:0]          imem_addr;
    rv_pkg::inst_t        imem_rdata;
    logic [31:0]          dmem_addr;
    logic [31:0]          dmem_wdata;
    logic                 dmem_we;
    logic [31:0]          dmem_rdata;
    logic                 trace_valid;
    rv_pkg::trace_t       trace;

    rv_pkg::inst_t        imem [512];
    logic [31:0]          dmem [256];
    logic [31:0]          dmem_init [256];
    logic [4:0]           exp_rd [$];
    logic [31:0]          exp_data [$];
    logic [31:0]          exp_st_addr [$];
    logic [31:0]          exp_st_data [$];
    logic [31:0]          rng = 32'hccab;
    int                   n_inst = 0;
    int                   n_exec = 0;
    int                   tr_idx = 0;
    int                   st_idx = 0;
    int                   cycles = 0;
    int                   reset_edges = 0;
    int                   limit = 1000000;

    cpu_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_we     (dmem_we),
        .dmem_rdata  (dmem_rdata),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

    // --------------------
    // memory models
    // --------------------

    assign imem_rdata = imem[imem_addr[10:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // --------------------
    // helpers
    // --------------------

    function automatic logic [31:0] rand32();
        logic [31:0] s;
        s = rng;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng = s;
        return s;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    function automatic rv_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op, 2'b11};
    endfunction

    function automatic rv_pkg::inst_t enc_i(input rv_pkg::opcode_e opc, input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic rv_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::opc_store, 2'b11};
    endfunction

    function automatic rv_pkg::inst_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::opc_branch, 2'b11};
    endfunction

    function automatic rv_pkg::inst_t enc_u(input rv_pkg::opcode_e opc, input logic [19:0] imm,
            input logic [4:0] rd);
        return {imm, rd, opc, 2'b11};
    endfunction

    function automatic rv_pkg::inst_t enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opc_jal, 2'b11};
    endfunction

    task automatic emit(input rv_pkg::inst_t inst);
        imem[n_inst] = inst;
        n_inst = n_inst + 1;
    endtask

    // unused instruction slots hold ADDI x0 with the slot index as immediate
    task automatic fill_memories();
        for (int i = 0; i < 512; i++) begin
            imem[i] = enc_i(rv_pkg::opc_op_imm, {3'b000, i[8:0]}, 5'd0, 3'b000, 5'd0);
        end
        for (int i = 0; i < 256; i++) begin
            dmem_init[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
            dmem[i] = dmem_init[i];
        end
    endtask

    // --------------------
    // program generation
    // --------------------

    task automatic build_program();
        logic [31:0] r;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [2:0]  fns [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        logic [4:0]  ra [3] = '{5'd22, 5'd23, 5'd23};
        logic [4:0]  rb [3] = '{5'd23, 5'd22, 5'd24};
        // random upper and lower halves give plenty of negative values
        for (int i = 1; i < 16; i++) begin
            r = rand32();
            emit(enc_u(rv_pkg::opc_lui, r[31:12], 5'(i)));
            emit(enc_i(rv_pkg::opc_op_imm, r[11:0], 5'(i), 3'b000, 5'(i)));
        end
        for (int i = 0; i < 60; i++) begin
            r = rand32();
            imm = r[31:20];
            if (r[16]) begin
                f7 = (r[17] && (r[15:13] == 3'b000 || r[15:13] == 3'b101)) ? 7'h20 : 7'h00;
                emit(enc_r(f7, {1'b0, r[12:9]}, {1'b0, r[8:5]}, r[15:13], {1'b0, r[3:0]}));
            end else begin
                if (r[15:13] == 3'b001) begin
                    imm = {7'h00, imm[4:0]};
                end else if (r[15:13] == 3'b101) begin
                    imm = {r[17] ? 7'h20 : 7'h00, imm[4:0]};
                end
                emit(enc_i(rv_pkg::opc_op_imm, imm, {1'b0, r[8:5]}, r[15:13], {1'b0, r[3:0]}));
            end
        end
        // upper immediates and jumps, the JALR offset is odd on purpose
        r = rand32();
        emit(enc_u(rv_pkg::opc_auipc, r[31:12], 5'd16));
        emit(enc_j(5'd17, 21'd8));
        emit(enc_i(rv_pkg::opc_op_imm, 12'd1, 5'd0, 3'b000, 5'd18));
        emit(enc_u(rv_pkg::opc_auipc, 20'd0, 5'd19));
        emit(enc_i(rv_pkg::opc_jalr, 12'd13, 5'd19, 3'b000, 5'd20));
        emit(enc_i(rv_pkg::opc_op_imm, 12'd2, 5'd0, 3'b000, 5'd18));
        emit(enc_i(rv_pkg::opc_op_imm, 12'd4, 5'd20, 3'b000, 5'd21));
        // an odd PC left by the JALR would show up in this AUIPC
        emit(enc_u(rv_pkg::opc_auipc, 20'd0, 5'd18));
        // branches on -1, 1, 1 so signed and unsigned compares disagree
        emit(enc_i(rv_pkg::opc_op_imm, 12'hfff, 5'd0, 3'b000, 5'd22));
        emit(enc_i(rv_pkg::opc_op_imm, 12'd1, 5'd0, 3'b000, 5'd23));
        emit(enc_i(rv_pkg::opc_op_imm, 12'd1, 5'd0, 3'b000, 5'd24));
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                emit(enc_b(fns[f], ra[p], rb[p], 13'd8));
                emit(enc_i(rv_pkg::opc_op_imm, 12'(f * 3 + p + 1), 5'd0, 3'b000, 5'd25));
                emit(enc_i(rv_pkg::opc_op_imm, 12'(f * 3 + p + 100), 5'd0, 3'b000, 5'd26));
            end
        end
        // word stores and loads around 0x200
        emit(enc_i(rv_pkg::opc_op_imm, 12'h200, 5'd0, 3'b000, 5'd27));
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            imm = {{2{r[7]}}, r[7:0], 2'b00};
            emit(enc_s(imm, {1'b0, r[11:8]}, 5'd27));
            emit(enc_i(rv_pkg::opc_load, imm, 5'd27, 3'b010, 5'd28));
            emit(enc_i(rv_pkg::opc_load, {{2{r[19]}}, r[19:12], 2'b00}, 5'd27, 3'b010, 5'd29));
            emit(enc_r(7'h00, 5'd29, 5'd28, 3'b000, 5'd30));
        end
        // x0 ignores writes and reads as zero
        emit(enc_i(rv_pkg::opc_op_imm, 12'd7, 5'd1, 3'b000, 5'd0));
        emit(enc_u(rv_pkg::opc_lui, 20'habcde, 5'd0));
        emit(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd31));
        emit(enc_j(5'd0, 21'd0));
    endtask

    // --------------------
    // ISA reference
    // --------------------

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // runs the program until the self-jump, returns the executed count
    function automatic int run_model();
        logic [31:0] xr [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        wr;
        int          n;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = dmem_init[i];
        end
        pc = '0;
        n = 0;
        while (n < 4096) begin
            inst = imem[pc[10:2]];
            n = n + 1;
            if (inst == self_jump) begin
                break;
            end
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            imm_u = {inst[31:12], 12'b0};
            imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            a = xr[inst[19:15]];
            b = xr[inst[24:20]];
            next = pc + 32'd4;
            res = '0;
            wr = 1'b1;
            case (inst[6:2])
                rv_pkg::opc_lui:    res = imm_u;
                rv_pkg::opc_auipc:  res = pc + imm_u;
                rv_pkg::opc_jal: begin
                    res = pc + 32'd4;
                    next = pc + imm_j;
                end
                rv_pkg::opc_jalr: begin
                    res = pc + 32'd4;
                    next = (a + imm_i) & ~32'd1;
                end
                rv_pkg::opc_branch: begin
                    wr = 1'b0;
                    if (branch_taken(inst[14:12], a, b)) begin
                        next = pc + imm_b;
                    end
                end
                rv_pkg::opc_load: begin
                    addr = a + imm_i;
                    res = mem[addr[9:2]];
                end
                rv_pkg::opc_store: begin
                    wr = 1'b0;
                    addr = a + imm_s;
                    mem[addr[9:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                rv_pkg::opc_op_imm:
                    res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, imm_i);
                default:
                    res = alu_ref(inst[14:12], inst[30], a, b);
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                xr[inst[11:7]] = res;
                exp_rd.push_back(inst[11:7]);
                exp_data.push_back(res);
            end
            pc = next;
        end
        return n;
    endfunction

    // --------------------
    // compare and timeout
    // --------------------

    always @(posedge clk) begin
        if (rst) begin
            if (reset_edges > 0) begin
                check_value("trace_valid", 32'(trace_valid), 32'd0);
                check_value("dmem_we", 32'(dmem_we), 32'd0);
            end
            reset_edges <= reset_edges + 1;
        end else begin
            if (trace_valid) begin
                if (tr_idx >= exp_rd.size()) begin
                    report_failure("a register write appeared after the last expected one");
                end else begin
                    check_value("trace.rd", 32'(trace.rd), 32'(exp_rd[tr_idx]));
                    check_value("trace.data", trace.data, exp_data[tr_idx]);
                    tr_idx <= tr_idx + 1;
                end
            end
            if (dmem_we) begin
                if (st_idx >= exp_st_addr.size()) begin
                    report_failure("a store appeared after the last expected one");
                end else begin
                    check_value("dmem_addr", dmem_addr, exp_st_addr[st_idx]);
                    check_value("dmem_wdata", dmem_wdata, exp_st_data[st_idx]);
                    st_idx <= st_idx + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
            if (cycles >= limit) begin
                report_failure($sformatf("timeout after %0d cycles out of reset", cycles));
            end
        end
    end

    initial begin
        rst = 1'b1;
        fill_memories();
        build_program();
        n_exec = run_model();
        limit = 3 * n_exec + 50;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        while (tr_idx < exp_rd.size() || st_idx < exp_st_addr.size()) begin
            @(posedge clk);
        end
        // a few more cycles so a stray write after the end is still caught
        repeat (10) @(posedge clk);
        if (tr_idx == exp_rd.size() && st_idx == exp_st_addr.size()) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("not every expected register write and store was seen");
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
